// File: compile.f
source/snh_pkg.sv
source/snh_cfg_if.sv
source/snh_cfg_regs.sv
source/snh_skew_delay.sv
source/snh_lpf.sv
source/snh_hold_bank.sv
source/snh_top.sv
verification/snh_chk.sv
verification/snh_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then scan the log for failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module snh_tb -Mdir obj_dir -o snh_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/snh_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "TEST PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

// File: source/snh_cfg_if.sv
// configuration interface between register block and datapath, with modports

`timescale 1ns/1ps
`default_nettype none

interface snh_cfg_if;
    import snh_pkg::*;

    logic [skew_w-1:0]  skew;         // (-) delay in samples
    logic [shift_w-1:0] pole1_shift;  // section 1 coefficient as right shift
    logic [shift_w-1:0] pole2_shift;  // section 2 coefficient as right shift
    logic               lpf_bypass;   // route input around the filter

    // register side drives everything
    modport regs (
        output skew,
        output pole1_shift,
        output pole2_shift,
        output lpf_bypass
    );

    // skew line and filter only look
    modport dp (
        input skew,
        input pole1_shift,
        input pole2_shift,
        input lpf_bypass
    );

endinterface

`default_nettype wire

// File: source/snh_cfg_regs.sv
// config register block: masked writes, registered readback, drives the cfg interface

`timescale 1ns/1ps
`default_nettype none

module snh_cfg_regs (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cfg_we,     // single-cycle write strobe
    input  snh_pkg::cfg_addr_t             cfg_addr,
    input  logic [snh_pkg::cfg_data_w-1:0] cfg_wdata,
    output logic [snh_pkg::cfg_data_w-1:0] cfg_rdata,  // addressed reg, one cycle later
    snh_cfg_if.regs                        cfg
);
    import snh_pkg::*;

    logic [cfg_data_w-1:0] rd_mux;  // zero-extended view of the addressed field

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    // each field only keeps its own width, upper bits dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.skew        <= '0;
            cfg.pole1_shift <= '0;
            cfg.pole2_shift <= '0;
            cfg.lpf_bypass  <= 1'b0;
        end else if (cfg_we) begin
            case (cfg_addr)
                addr_skew:  cfg.skew        <= cfg_wdata[skew_w-1:0];
                addr_pole1: cfg.pole1_shift <= cfg_wdata[shift_w-1:0];
                addr_pole2: cfg.pole2_shift <= cfg_wdata[shift_w-1:0];
                addr_ctrl:  cfg.lpf_bypass  <= cfg_wdata[0];
                default: ;  // full 2-bit map decoded above
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////

    always_comb begin
        rd_mux = '0;
        case (cfg_addr)
            addr_skew:  rd_mux = cfg_data_w'(cfg.skew);
            addr_pole1: rd_mux = cfg_data_w'(cfg.pole1_shift);
            addr_pole2: rd_mux = cfg_data_w'(cfg.pole2_shift);
            addr_ctrl:  rd_mux = cfg_data_w'(cfg.lpf_bypass);
            default:    rd_mux = '0;
        endcase
    end

    // readback registered, so rdata trails the address by a cycle
    // a write and read of the same reg in one cycle returns the old value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_rdata <= '0;
        end else begin
            cfg_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: source/snh_hold_bank.sv
// round-robin lane pointer and N_OUT differential hold registers with output strobe

`timescale 1ns/1ps
`default_nettype none

module snh_hold_bank #(
    parameter int N_OUT = snh_pkg::n_out   // number of hold lanes, 2 or more
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       filt_valid,
    input  snh_pkg::sample_t           filt_p,
    input  snh_pkg::sample_t           filt_n,
    output logic                       out_valid,        // one pulse per captured pair
    output logic [$clog2(N_OUT)-1:0]   out_lane,         // lane just written
    output snh_pkg::sample_t           out_p [N_OUT],
    output snh_pkg::sample_t           out_n [N_OUT]
);
    import snh_pkg::*;

    localparam int lane_w = $clog2(N_OUT);

    ////////////////////////////////////////////////////////////
    // lane pointer
    ////////////////////////////////////////////////////////////

    // stands in for the interleaved per-lane sampling clocks
    logic [lane_w-1:0] ptr;
    logic [lane_w-1:0] ptr_nxt;

    always_comb begin
        if (ptr == lane_w'(N_OUT - 1)) begin
            ptr_nxt = '0;              // wrap, N_OUT need not be a power of 2
        end else begin
            ptr_nxt = ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr       <= '0;
            out_valid <= 1'b0;
            out_lane  <= '0;
        end else begin
            out_valid <= filt_valid;   // strobe one cycle behind the input
            if (filt_valid) begin
                out_lane <= ptr;
                ptr      <= ptr_nxt;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // hold lanes
    ////////////////////////////////////////////////////////////

    // only the pointed lane captures, the rest keep their value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < N_OUT; k++) begin
                out_p[k] <= '0;
                out_n[k] <= '0;
            end
        end else if (filt_valid) begin
            for (int k = 0; k < N_OUT; k++) begin
                if (ptr == lane_w'(k)) begin
                    out_p[k] <= filt_p;
                    out_n[k] <= filt_n;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/snh_lpf.sv
// two-section shift-coefficient low-pass per side, fixed two-cycle latency, with bypass

`timescale 1ns/1ps
`default_nettype none

module snh_lpf (
    input  logic             clk,
    input  logic             rst_n,
    snh_cfg_if.dp            cfg,
    input  logic             dly_valid,
    input  snh_pkg::sample_t dly_p,
    input  snh_pkg::sample_t dly_n,
    output logic             filt_valid,  // dly_valid + 2 cycles
    output snh_pkg::sample_t filt_p,
    output snh_pkg::sample_t filt_n
);
    import snh_pkg::*;

    localparam int st_w = sample_w + 1;   // one guard bit on the state

    typedef logic signed [st_w-1:0] state_t;

    sample_t x    [2];   // side 0 = (+), side 1 = (-)
    state_t  s1   [2];   // first pole state
    state_t  s2   [2];   // second pole state, feeds the output
    sample_t byp1 [2];   // bypass path, stage 1
    sample_t byp2 [2];   // bypass path, stage 2
    logic    v1;         // section 1 updated last cycle
    logic    v2;

    // s + ((in - s) >>> sh), floor rounding from the arithmetic shift
    function automatic state_t pole_step(state_t s, state_t in, logic [shift_w-1:0] sh);
        logic signed [st_w:0] diff;
        logic signed [st_w:0] sum;
        diff = in - s;          // one more bit, no wrap
        diff = diff >>> sh;
        sum  = s + diff;
        return state_t'(sum);   // result lies between s and in
    endfunction

    // clip the guarded state back to a sample
    function automatic sample_t sat(state_t v);
        if (v[st_w-1] != v[st_w-2]) begin
            return v[st_w-1] ? {1'b1, {(sample_w-1){1'b0}}} : {1'b0, {(sample_w-1){1'b1}}};
        end
        return sample_t'(v);
    endfunction

    assign x[0] = dly_p;
    assign x[1] = dly_n;

    // filter states move only on valid, bypass or not
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            for (int i = 0; i < 2; i++) begin
                s1[i] <= '0;
                s2[i] <= '0;
            end
        end else begin
            v1 <= dly_valid;
            v2 <= v1;
            for (int i = 0; i < 2; i++) begin
                if (dly_valid) s1[i] <= pole_step(s1[i], state_t'(x[i]), cfg.pole1_shift);
                if (v1)        s2[i] <= pole_step(s2[i], s1[i], cfg.pole2_shift);
            end
        end
    end

    // raw samples follow the same two stages
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (dly_valid) byp1[i] <= x[i];
            if (v1)        byp2[i] <= byp1[i];
        end
    end

    assign filt_valid = v2;
    assign filt_p     = cfg.lpf_bypass ? byp2[0] : sat(s2[0]);
    assign filt_n     = cfg.lpf_bypass ? byp2[1] : sat(s2[1]);

endmodule

`default_nettype wire

// File: source/snh_pkg.sv
// sample widths, lane count, config register map and the sample type

`default_nettype none

package snh_pkg;

    ////////////////////////////////////////////////////////////
    // datapath sizing
    ////////////////////////////////////////////////////////////

    localparam int sample_w = 16;   // one input sample, two's complement
    localparam int n_out    = 4;    // default hold lane count
    localparam int max_skew = 15;   // deepest programmable (-) delay, in samples

    localparam int lane_idx_w = $clog2(n_out);  // lane index for the default lane count

    // signed sample word, used for both sides of the pair
    typedef logic signed [sample_w-1:0] sample_t;

    ////////////////////////////////////////////////////////////
    // configuration register map
    ////////////////////////////////////////////////////////////

    localparam int skew_w     = 4;  // skew field
    localparam int shift_w    = 4;  // pole shift field, 0..15
    localparam int cfg_data_w = 8;  // bus data width, fields zero-extended

    typedef logic [1:0] cfg_addr_t;

    localparam cfg_addr_t addr_skew  = 2'd0;  // (-) side delay
    localparam cfg_addr_t addr_pole1 = 2'd1;  // first section shift
    localparam cfg_addr_t addr_pole2 = 2'd2;  // second section shift
    localparam cfg_addr_t addr_ctrl  = 2'd3;  // bit 0 = lpf bypass

endpackage

`default_nettype wire

// File: source/snh_skew_delay.sv
// input register stage with programmable sample delay on the (-) side

`timescale 1ns/1ps
`default_nettype none

module snh_skew_delay #(
    parameter int MAX_SKEW = snh_pkg::max_skew   // history depth minus one
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,   // one strobe per sample pair
    input  snh_pkg::sample_t in_p,
    input  snh_pkg::sample_t in_n,
    snh_cfg_if.dp            cfg,
    output logic             dly_valid,
    output snh_pkg::sample_t dly_p,
    output snh_pkg::sample_t dly_n       // in_n from skew strobes back
);
    import snh_pkg::*;

    sample_t hist [MAX_SKEW+1];  // hist[0] = newest in_n, hist[k] = k strobes older
    int      tap;                // clamped history index

    // shift on strobe only, so delay counts samples and not cycles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dly_valid <= 1'b0;
            for (int k = 0; k <= MAX_SKEW; k++) begin
                hist[k] <= '0;   // pre-reset history reads back as 0
            end
        end else begin
            dly_valid <= in_valid;
            if (in_valid) begin
                hist[0] <= in_n;
                for (int k = 1; k <= MAX_SKEW; k++) begin
                    hist[k] <= hist[k-1];
                end
            end
        end
    end

    // (+) side gets one plain register to line up with hist[0]
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dly_p <= in_p;
        end
    end

    // skew field may be wider than the line for a short MAX_SKEW, clamp it
    always_comb begin
        tap = (int'(cfg.skew) > MAX_SKEW) ? MAX_SKEW : int'(cfg.skew);
    end

    assign dly_n = hist[tap];   // tap of registered history, aligned with dly_p

endmodule

`default_nettype wire

// File: source/snh_top.sv
// top level: config registers, skew delay, low-pass filter and hold bank

`timescale 1ns/1ps
`default_nettype none

module snh_top #(
    parameter int N_OUT    = snh_pkg::n_out,     // hold lanes
    parameter int MAX_SKEW = snh_pkg::max_skew   // deepest (-) delay
) (
    input  logic                           clk,
    input  logic                           rst_n,
    // sample stream
    input  logic                           in_valid,
    input  snh_pkg::sample_t               in_p,
    input  snh_pkg::sample_t               in_n,
    // config port
    input  logic                           cfg_we,
    input  snh_pkg::cfg_addr_t             cfg_addr,
    input  logic [snh_pkg::cfg_data_w-1:0] cfg_wdata,
    output logic [snh_pkg::cfg_data_w-1:0] cfg_rdata,
    // held lanes
    output logic                           out_valid,   // in_valid + 4 cycles
    output logic [$clog2(N_OUT)-1:0]       out_lane,
    output snh_pkg::sample_t               out_p [N_OUT],
    output snh_pkg::sample_t               out_n [N_OUT]
);
    import snh_pkg::*;

    ////////////////////////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////////////////////////

    logic    dly_valid;    // skew stage out, +1
    sample_t dly_p;
    sample_t dly_n;
    logic    filt_valid;   // filter out, +3
    sample_t filt_p;
    sample_t filt_n;

    snh_cfg_if cfg_if ();

    snh_cfg_regs cfg_regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg_if.regs)
    );

    snh_skew_delay #(.MAX_SKEW(MAX_SKEW)) skew_delay_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_p      (in_p),
        .in_n      (in_n),
        .cfg       (cfg_if.dp),
        .dly_valid (dly_valid),
        .dly_p     (dly_p),
        .dly_n     (dly_n)
    );

    snh_lpf lpf_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg_if.dp),
        .dly_valid  (dly_valid),
        .dly_p      (dly_p),
        .dly_n      (dly_n),
        .filt_valid (filt_valid),
        .filt_p     (filt_p),
        .filt_n     (filt_n)
    );

    snh_hold_bank #(.N_OUT(N_OUT)) hold_bank_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .filt_valid (filt_valid),
        .filt_p     (filt_p),
        .filt_n     (filt_n),
        .out_valid  (out_valid),
        .out_lane   (out_lane),
        .out_p      (out_p),
        .out_n      (out_n)
    );

endmodule

`default_nettype wire

// File: verification/snh_chk.sv
// concurrent assertions on the hold bank strobe and lane pointer, plus the bind

`timescale 1ns/1ps
`default_nettype none

module snh_chk #(
    parameter int N_OUT = snh_pkg::n_out
) (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     filt_valid,
    input logic                     out_valid,
    input logic [$clog2(N_OUT)-1:0] out_lane
);

    int fails = 0;   // failed assertion count

    ////////////////////////////////////////////////////////////
    // strobe and pointer properties
    ////////////////////////////////////////////////////////////

    // a long out_valid is only legal as back-to-back captures, lane moves each cycle
    a_single: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && $past(out_valid) |-> out_lane != $past(out_lane))
        else begin
            fails++;
            $error("out_valid held over two cycles on the same lane");
        end

    a_lane_range: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> int'(out_lane) < N_OUT)
        else begin
            fails++;
            $error("out_lane points past the last lane");
        end

    // strobe exactly one cycle behind filt_valid
    a_follow: assert property (@(posedge clk) disable iff (!rst_n)
        filt_valid |=> out_valid)
        else begin
            fails++;
            $error("out_valid missing one cycle after filt_valid");
        end

    a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        !filt_valid |=> !out_valid)
        else begin
            fails++;
            $error("out_valid without filt_valid one cycle earlier");
        end

endmodule

bind snh_hold_bank snh_chk #(.N_OUT(N_OUT)) chk_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .filt_valid (filt_valid),
    .out_valid  (out_valid),
    .out_lane   (out_lane)
);

`default_nettype wire

// File: verification/snh_tb.sv
// testbench: clock, reset, reference model, directed tests, check task, watchdog, summary

`timescale 1ns/1ps
`default_nettype none

module snh_tb;
    import snh_pkg::*;

    localparam int N_OUT    = 3;   // odd lane count, pointer must wrap before its width does
    localparam int MAX_SKEW = max_skew;
    localparam int period   = 8;
    // samples of all tests plus register cycles
    localparam int n_stim   = 4*N_OUT + 2*(MAX_SKEW+8) + 44 + 8 + 30;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     in_valid;
    sample_t                  in_p;
    sample_t                  in_n;
    logic                     cfg_we;
    cfg_addr_t                cfg_addr;
    logic [cfg_data_w-1:0]    cfg_wdata;
    logic [cfg_data_w-1:0]    cfg_rdata;
    logic                     out_valid;
    logic [$clog2(N_OUT)-1:0] out_lane;
    sample_t                  out_p [N_OUT];
    sample_t                  out_n [N_OUT];

    // reference model state
    int m_skew;
    int m_sh1;
    int m_sh2;
    int m_byp;
    int ptr_m;
    int hist [MAX_SKEW+1];        // in_n history, 0 = newest
    int s1 [2];                   // section states, 0 = (+) side
    int s2 [2];
    int lane_p [N_OUT];           // shadow of the held lanes
    int lane_n [N_OUT];
    int q_lane[$];
    int q_p[$];
    int q_n[$];
    time q_t[$];                  // drive time of each sample in flight

    int errors     = 0;
    int checks     = 0;
    int tests      = 0;
    int pulses_in  = 0;
    int pulses_out = 0;

    snh_top #(.N_OUT(N_OUT), .MAX_SKEW(MAX_SKEW)) snh_top_i (.*);

    initial begin
        forever #(period/2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // one section: s + (x - s) >>> sh, floor
    function automatic int pole(int s, int x, int sh);
        return s + ((x - s) >>> sh);
    endfunction

    function automatic int clip(int v);
        if (v > (1 << (sample_w-1)) - 1) return (1 << (sample_w-1)) - 1;
        if (v < -(1 << (sample_w-1))) return -(1 << (sample_w-1));
        return v;
    endfunction

    function automatic logic [7:0] field_mask(cfg_addr_t a);
        return (a == addr_ctrl) ? 8'h01 : 8'h0f;   // bypass bit, else 4-bit field
    endfunction

    // expected lane and pair for one accepted strobe
    function automatic void predict(int p, int n);
        int x [2];
        for (int k = MAX_SKEW; k > 0; k--) begin
            hist[k] = hist[k-1];
        end
        hist[0] = n;
        x[0] = p;
        x[1] = hist[m_skew];
        for (int i = 0; i < 2; i++) begin
            s1[i] = pole(s1[i], x[i], m_sh1);   // states run in bypass too
            s2[i] = pole(s2[i], s1[i], m_sh2);
        end
        q_lane.push_back(ptr_m);
        q_p.push_back(m_byp ? x[0] : clip(s2[0]));
        q_n.push_back(m_byp ? x[1] : clip(s2[1]));
        ptr_m = (ptr_m + 1) % N_OUT;
    endfunction

    function automatic void model_reset();
        m_skew = 0;
        m_sh1  = 0;
        m_sh2  = 0;
        m_byp  = 0;
        ptr_m  = 0;
        foreach (hist[k]) hist[k] = 0;
        for (int i = 0; i < 2; i++) begin
            s1[i] = 0;
            s2[i] = 0;
        end
        for (int k = 0; k < N_OUT; k++) begin
            lane_p[k] = 0;
            lane_n[k] = 0;
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // drivers, checker, monitor
    ////////////////////////////////////////////////////////////

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic do_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        model_reset();
    endtask

    task automatic reg_write(cfg_addr_t a, logic [7:0] d);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= a;
        cfg_wdata <= d;
        @(posedge clk);
        cfg_we <= 1'b0;
        case (a)
            addr_skew:  m_skew = int'(d & field_mask(a));
            addr_pole1: m_sh1  = int'(d & field_mask(a));
            addr_pole2: m_sh2  = int'(d & field_mask(a));
            default:    m_byp  = int'(d & field_mask(a));
        endcase
    endtask

    task automatic reg_read(cfg_addr_t a, output logic [7:0] d);
        @(posedge clk);
        cfg_addr <= a;
        @(posedge clk);           // readback registered here
        @(negedge clk);
        d = cfg_rdata;
    endtask

    // one strobe, then idle cycles; idle 0 keeps the stream back to back
    task automatic send(sample_t p, sample_t n, int idle);
        @(posedge clk);
        in_valid <= 1'b1;
        in_p     <= p;
        in_n     <= n;
        predict(int'(p), int'(n));
        q_t.push_back($time);
        pulses_in++;
        repeat (idle) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        in_valid <= 1'b0;
        while (q_lane.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (q_lane.size() != 0) begin
            errors++;
            $display("%0d expected outputs never appeared", q_lane.size());
            q_lane.delete();
            q_p.delete();
            q_n.delete();
            q_t.delete();
        end
    endtask

    // outputs sampled mid-cycle, all lanes against the shadow copy
    always @(negedge clk) begin : monitor
        int lane;
        int lat;
        if (rst_n && out_valid) begin
            pulses_out++;
            if (q_lane.size() == 0) begin
                errors++;
                $display("out_valid pulsed with no sample in flight at %0t", $time);
            end else begin
                lane = q_lane.pop_front();
                lane_p[lane] = q_p.pop_front();
                lane_n[lane] = q_n.pop_front();
                lat = int'(($time - q_t.pop_front() - period/2) / period);
                check("out_lane", 32'(out_lane), lane);
                check("latency", lat, 4);
                for (int k = 0; k < N_OUT; k++) begin
                    check($sformatf("out_p[%0d]", k), 32'(out_p[k]), lane_p[k]);
                    check($sformatf("out_n[%0d]", k), 32'(out_n[k]), lane_n[k]);
                end
            end
        end
    end

    task automatic test_done(string name, int err0);
        tests++;
        $display("test %s: %0d errors", name, errors - err0);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        int err0;
        logic [7:0] d;
        err0 = errors;
        do_reset();
        repeat (8) begin
            @(negedge clk);
            check("out_valid", 32'(out_valid), 0);
        end
        for (int k = 0; k < N_OUT; k++) begin
            check($sformatf("out_p[%0d]", k), 32'(out_p[k]), 0);
            check($sformatf("out_n[%0d]", k), 32'(out_n[k]), 0);
        end
        for (int a = 0; a < 4; a++) begin
            reg_read(cfg_addr_t'(a), d);
            check("cfg_rdata", 32'(d), 0);
        end
        test_done("reset", err0);
    endtask

    task automatic test_regs();
        int err0;
        logic [7:0] v;
        logic [7:0] d;
        err0 = errors;
        for (int a = 0; a < 4; a++) begin
            v = 8'($urandom());
            reg_write(cfg_addr_t'(a), v);
            reg_read(cfg_addr_t'(a), d);
            check("cfg_rdata", 32'(d), 32'(v & field_mask(cfg_addr_t'(a))));
        end
        test_done("registers", err0);
    endtask

    task automatic test_interleave();
        int err0;
        err0 = errors;
        reg_write(addr_ctrl, 8'h01);
        reg_write(addr_skew, 8'h00);
        for (int k = 0; k < 4*N_OUT; k++) begin
            send(sample_t'($urandom()), sample_t'($urandom()), int'($urandom() % 3));
        end
        drain();
        test_done("interleave", err0);
    endtask

    task automatic test_skew();
        int err0;
        int skews [2];
        err0 = errors;
        skews[0] = 1;
        skews[1] = MAX_SKEW;
        foreach (skews[j]) begin
            do_reset();                  // empty history, early out_n must be 0
            reg_write(addr_ctrl, 8'h01);
            reg_write(addr_skew, 8'(skews[j]));
            for (int k = 0; k < MAX_SKEW + 8; k++) begin
                send(sample_t'($urandom()), sample_t'($urandom()), int'($urandom() % 2));
            end
            drain();
        end
        test_done("skew", err0);
    endtask

    task automatic test_filter();
        int err0;
        err0 = errors;
        reg_write(addr_skew, 8'h00);
        reg_write(addr_pole1, 8'h02);
        reg_write(addr_pole2, 8'h03);
        reg_write(addr_ctrl, 8'h00);
        for (int k = 0; k < 8; k++) begin
            send(sample_t'(16000), sample_t'(-16000), int'($urandom() % 2));  // step
        end
        for (int k = 0; k < 24; k++) begin
            send(sample_t'($urandom()), sample_t'($urandom()), int'($urandom() % 3));
        end
        drain();
        reg_write(addr_pole1, 8'h00);    // plain register per section
        reg_write(addr_pole2, 8'h00);
        for (int k = 0; k < 12; k++) begin
            send(sample_t'($urandom()), sample_t'($urandom()), 1);
        end
        drain();
        test_done("filter", err0);
    endtask

    task automatic test_latency();
        int err0;
        err0 = errors;
        for (int k = 0; k < 8; k++) begin
            send(sample_t'($urandom()), sample_t'($urandom()), 10);   // isolated
        end
        drain();
        check("pulse count", pulses_out, pulses_in);
        test_done("latency", err0);
    endtask

    initial begin : main
        int seed;
        seed      = $urandom(4);
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_p      = '0;
        in_n      = '0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        model_reset();
        test_reset();
        test_regs();
        test_interleave();
        test_skew();
        test_filter();
        test_latency();
        repeat (4) @(posedge clk);
        errors += snh_top_i.hold_bank_i.chk_i.fails;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (n_stim * 8 + 400) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
